// ==== Makefile ====
TOP := maze_display_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f -Mdir obj_dir -o $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+include
logic/maze_pkg.sv
logic/region_locator.sv
logic/pixel_painter.sv
logic/maze_display.sv
tb/maze_display_asserts.sv
tb/maze_display_tb.sv

// ==== include/maze_defs.svh ====
`ifndef MAZE_DEFS_SVH
`define MAZE_DEFS_SVH

//////////////////////////////
// Screen and maze geometry
//////////////////////////////

`define COORD_W      7
`define MAZE_COLS    5
`define MAZE_ROWS    4
`define CELL_COUNT   20

// Wall map, vertical walls first
`define WALL_BITS    31
`define VWALL_COUNT  16

// Outer border
`define LEFT_EDGE    11
`define RIGHT_EDGE   85
`define TOP_EDGE     2
`define BOTTOM_EDGE  61

// Inner wall lines every pitch from the left and top edges
`define CELL_PITCH   15

//////////////////////////////
// RGB565 colours
//////////////////////////////

`define COLOR_BLACK  16'b00000_000000_00000
`define COLOR_WHITE  16'b11111_111111_11111
`define COLOR_RED    16'b11111_000000_00000

`endif

// ==== logic/maze_display.sv ====
`timescale 1ns/1ps
`include "maze_defs.svh"

module maze_display
    import maze_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [`COORD_W-1:0]   x,
    input  logic [`COORD_W-1:0]   y,
    input  logic [`WALL_BITS-1:0] maze,
    input  logic [4:0]            position,
    output color_t                oled_data
);

    // One pixel per clock, colour two cycles after the coordinate
    pixel_region_t region;

    region_locator u_region_locator (
        .clock  (clock),
        .arst_n (arst_n),
        .x      (x),
        .y      (y),
        .region (region)
    );

    // Maze and position are sampled with the region, one cycle late
    pixel_painter u_pixel_painter (
        .clock     (clock),
        .arst_n    (arst_n),
        .region    (region),
        .maze      (maze),
        .position  (position),
        .oled_data (oled_data)
    );

endmodule

// ==== logic/maze_pkg.sv ====
package maze_pkg;

    //////////////////////////////
    // Region classification
    //////////////////////////////

    typedef enum logic [2:0] {
        REGION_BACKGROUND,
        REGION_BORDER,
        REGION_VWALL,
        REGION_HWALL,
        REGION_CELL
    } region_kind_e;

    // Index is the wall bit or the cell number
    typedef struct packed {
        region_kind_e kind;
        logic [4:0]   index;
    } pixel_region_t;

    //////////////////////////////
    // Display colour
    //////////////////////////////

    // RGB565 field order
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } color_t;

endpackage

// ==== logic/pixel_painter.sv ====
`timescale 1ns/1ps
`include "maze_defs.svh"

module pixel_painter
    import maze_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  pixel_region_t         region,
    input  logic [`WALL_BITS-1:0] maze,
    input  logic [4:0]            position,
    output color_t                oled_data
);

    color_t wall_color;
    color_t cell_color;
    color_t color_next;

    // Set wall bit draws the wall
    assign wall_color = maze[region.index] ? color_t'(`COLOR_BLACK) : color_t'(`COLOR_WHITE);

    // Out of range positions never match a cell index
    assign cell_color = (position == region.index) ? color_t'(`COLOR_RED)
                                                   : color_t'(`COLOR_WHITE);

    always_comb begin
        unique case (region.kind)
            REGION_BORDER: begin
                color_next = color_t'(`COLOR_BLACK);
            end
            REGION_VWALL, REGION_HWALL: begin
                color_next = wall_color;
            end
            REGION_CELL: begin
                color_next = cell_color;
            end
            default: begin
                color_next = color_t'(`COLOR_WHITE);
            end
        endcase
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            oled_data <= color_t'(`COLOR_BLACK);
        end else begin
            oled_data <= color_next;
        end
    end

endmodule

// ==== logic/region_locator.sv ====
`timescale 1ns/1ps
`include "maze_defs.svh"

module region_locator
    import maze_pkg::*;
(
    input  logic                clock,
    input  logic                arst_n,
    input  logic [`COORD_W-1:0] x,
    input  logic [`COORD_W-1:0] y,
    output pixel_region_t       region
);

    localparam int V_WALLS = `MAZE_COLS - 1;
    localparam int H_LINES = `MAZE_ROWS - 1;

    logic [31:0]   xw;
    logic [31:0]   yw;

    logic          on_border;
    logic          vline_hit;
    logic [1:0]    vline_col;
    logic          seg_hit;
    logic [2:0]    seg_idx;
    logic          band_hit;
    logic [1:0]    band_idx;
    logic          hline_hit;
    logic [1:0]    hline_idx;
    logic          row_hit;
    logic [1:0]    row_idx;

    pixel_region_t region_next;

    function automatic logic in_range(logic [31:0] v, int lo, int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    assign xw = 32'(x);
    assign yw = 32'(y);

    assign on_border =
        (((xw == `LEFT_EDGE) || (xw == `RIGHT_EDGE)) && in_range(yw, `TOP_EDGE, `BOTTOM_EDGE)) ||
        (((yw == `TOP_EDGE) || (yw == `BOTTOM_EDGE)) && in_range(xw, `LEFT_EDGE, `RIGHT_EDGE));

    //////////////////////////////
    // Column decode
    //////////////////////////////

    always_comb begin
        vline_hit = 1'b0;
        vline_col = '0;
        seg_hit   = 1'b0;
        seg_idx   = '0;
        for (int c = 0; c < V_WALLS; c++) begin
            if (xw == `LEFT_EDGE + `CELL_PITCH * (c + 1)) begin
                vline_hit = 1'b1;
                vline_col = 2'(c);
            end
        end
        // Last segment ends on the right border column
        for (int s = 0; s < `MAZE_COLS; s++) begin
            if (in_range(xw, `LEFT_EDGE + 1 + `CELL_PITCH * s,
                         `LEFT_EDGE + `CELL_PITCH * (s + 1) - 1)) begin
                seg_hit = 1'b1;
                seg_idx = 3'(s);
            end
        end
    end

    //////////////////////////////
    // Row decode
    //////////////////////////////

    always_comb begin
        band_hit  = 1'b0;
        band_idx  = '0;
        hline_hit = 1'b0;
        hline_idx = '0;
        row_hit   = 1'b0;
        row_idx   = '0;
        // Bands include the horizontal line below them
        for (int b = 0; b < `MAZE_ROWS; b++) begin
            if (in_range(yw, `TOP_EDGE + 1 + `CELL_PITCH * b,
                         (b == `MAZE_ROWS - 1) ? `BOTTOM_EDGE - 1
                                               : `TOP_EDGE + `CELL_PITCH * (b + 1))) begin
                band_hit = 1'b1;
                band_idx = 2'(b);
            end
        end
        for (int l = 0; l < H_LINES; l++) begin
            if (yw == `TOP_EDGE + `CELL_PITCH * (l + 1)) begin
                hline_hit = 1'b1;
                hline_idx = 2'(l);
            end
        end
        for (int r = 0; r < `MAZE_ROWS; r++) begin
            if (in_range(yw, `TOP_EDGE + 1 + `CELL_PITCH * r,
                         (r == `MAZE_ROWS - 1) ? `BOTTOM_EDGE - 1
                                               : `TOP_EDGE + `CELL_PITCH * (r + 1) - 1)) begin
                row_hit = 1'b1;
                row_idx = 2'(r);
            end
        end
    end

    // Border, vertical wall, horizontal wall, cell, background
    always_comb begin
        region_next.kind  = REGION_BACKGROUND;
        region_next.index = '0;
        if (on_border) begin
            region_next.kind = REGION_BORDER;
        end else if (vline_hit && band_hit) begin
            region_next.kind  = REGION_VWALL;
            region_next.index = 5'(band_idx) * 5'(V_WALLS) + 5'(vline_col);
        end else if (hline_hit && seg_hit) begin
            region_next.kind  = REGION_HWALL;
            region_next.index = 5'(`VWALL_COUNT) + 5'(hline_idx) * 5'(`MAZE_COLS) + 5'(seg_idx);
        end else if (seg_hit && row_hit) begin
            region_next.kind  = REGION_CELL;
            region_next.index = 5'(row_idx) * 5'(`MAZE_COLS) + 5'(seg_idx);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            region.kind  <= REGION_BACKGROUND;
            region.index <= '0;
        end else begin
            region <= region_next;
        end
    end

endmodule

// ==== tb/maze_display_asserts.sv ====
`timescale 1ns/1ps
`include "maze_defs.svh"

module maze_display_asserts
    import maze_pkg::*;
(
    input logic          clock,
    input logic          arst_n,
    input pixel_region_t region,
    input color_t        oled_data
);

    //////////////////////////////
    // Output colours
    //////////////////////////////

    assert property (@(posedge clock) disable iff (!arst_n)
        (oled_data == color_t'(`COLOR_BLACK)) || (oled_data == color_t'(`COLOR_WHITE)) ||
        (oled_data == color_t'(`COLOR_RED)))
        else $error("oled_data is not black, white or red");

    // Async reset clears the output
    assert property (@(posedge clock)
        (!arst_n) |-> (oled_data == color_t'(`COLOR_BLACK)))
        else $error("oled_data not black during reset");

    //////////////////////////////
    // Region index ranges
    //////////////////////////////

    assert property (@(posedge clock) disable iff (!arst_n)
        (region.kind == REGION_CELL) |-> (region.index < `CELL_COUNT))
        else $error("cell index out of range");

    assert property (@(posedge clock) disable iff (!arst_n)
        ((region.kind == REGION_VWALL) || (region.kind == REGION_HWALL)) |->
        (region.index < `WALL_BITS))
        else $error("wall index out of range");

endmodule

bind maze_display maze_display_asserts u_asserts (
    .clock     (clock),
    .arst_n    (arst_n),
    .region    (region),
    .oled_data (oled_data)
);

// ==== tb/maze_display_tb.sv ====
`timescale 1ns/1ps
`include "maze_defs.svh"

module maze_display_tb
    import maze_pkg::*;
;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_COUNT  = 200;
    localparam int MARGIN_CYCLES = 60;

    localparam logic [`WALL_BITS-1:0] ALL_ONES = '1;
    localparam logic [`WALL_BITS-1:0] ALL_ZEROS = '0;
    localparam logic [`WALL_BITS-1:0] ALT_EVEN = 31'h5555_5555;
    localparam logic [`WALL_BITS-1:0] ALT_ODD = 31'h2AAA_AAAA;

    localparam color_t BLACK = color_t'(16'h0000);
    localparam color_t WHITE = color_t'(16'hFFFF);
    localparam color_t RED = color_t'(16'hF800);

    typedef struct packed {
        logic [`COORD_W-1:0]   x;
        logic [`COORD_W-1:0]   y;
        logic [`WALL_BITS-1:0] maze;
        logic [4:0]            position;
        color_t                expected;
    } pixel_case_t;

    logic                  clock = 1'b0;
    logic                  arst_n;
    logic [`COORD_W-1:0]   x;
    logic [`COORD_W-1:0]   y;
    logic [`WALL_BITS-1:0] maze;
    logic [4:0]            position;
    color_t                oled_data;

    pixel_case_t table_q[$];
    string       test_names[$];
    int          test_ends[$];
    logic        table_ready = 1'b0;
    integer      seed = 82138;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;

    maze_display uut (
        .clock     (clock),
        .arst_n    (arst_n),
        .x         (x),
        .y         (y),
        .maze      (maze),
        .position  (position),
        .oled_data (oled_data)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic color_t predict_color(input logic [`COORD_W-1:0] px,
                                             input logic [`COORD_W-1:0] py,
                                             input logic [`WALL_BITS-1:0] pmaze,
                                             input logic [4:0] ppos);
        int xi;
        int yi;
        int col;
        int seg;
        int band;
        int line;
        int row;
        int idx;
        xi = int'(px);
        yi = int'(py);
        col = (xi == 26) ? 0 : (xi == 41) ? 1 : (xi == 56) ? 2 : (xi == 71) ? 3 : -1;
        seg = (xi >= 12 && xi <= 25) ? 0 : (xi >= 27 && xi <= 40) ? 1 :
              (xi >= 42 && xi <= 55) ? 2 : (xi >= 57 && xi <= 70) ? 3 :
              (xi >= 72 && xi <= 85) ? 4 : -1;
        band = (yi >= 3 && yi <= 17) ? 0 : (yi >= 18 && yi <= 32) ? 1 :
               (yi >= 33 && yi <= 47) ? 2 : (yi >= 48 && yi <= 60) ? 3 : -1;
        line = (yi == 17) ? 0 : (yi == 32) ? 1 : (yi == 47) ? 2 : -1;
        row = (yi >= 3 && yi <= 16) ? 0 : (yi >= 18 && yi <= 31) ? 1 :
              (yi >= 33 && yi <= 46) ? 2 : (yi >= 48 && yi <= 60) ? 3 : -1;
        if (((xi == 11 || xi == 85) && yi >= 2 && yi <= 61) ||
            ((yi == 2 || yi == 61) && xi >= 11 && xi <= 85)) begin
            return BLACK;
        end
        if (col >= 0 && band >= 0) begin
            idx = band * 4 + col;
            return pmaze[idx] ? BLACK : WHITE;
        end
        if (line >= 0 && seg >= 0) begin
            idx = 16 + line * 5 + seg;
            return pmaze[idx] ? BLACK : WHITE;
        end
        if (seg >= 0 && row >= 0) begin
            idx = row * 5 + seg;
            return (int'(ppos) == idx) ? RED : WHITE;
        end
        return WHITE;
    endfunction

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    task automatic add_case(input int cx, input int cy, input logic [`WALL_BITS-1:0] cmaze,
                            input int cpos, input color_t cexp);
        pixel_case_t c;
        c.x        = 7'(cx);
        c.y        = 7'(cy);
        c.maze     = cmaze;
        c.position = 5'(cpos);
        c.expected = cexp;
        table_q.push_back(c);
    endtask

    task automatic mark_test(input string name);
        test_names.push_back(name);
        test_ends.push_back(table_q.size());
    endtask

    task automatic build_table();
        pixel_case_t c;
        // Corners and edges, including the segment end at x 85
        add_case(11, 2, ALL_ONES, 0, BLACK);
        add_case(85, 2, ALL_ONES, 0, BLACK);
        add_case(11, 61, ALL_ZEROS, 0, BLACK);
        add_case(85, 61, ALL_ZEROS, 0, BLACK);
        add_case(85, 17, ALL_ZEROS, 0, BLACK);
        add_case(85, 17, ALL_ONES, 0, BLACK);
        add_case(50, 2, ALL_ZEROS, 0, BLACK);
        add_case(11, 30, ALL_ZEROS, 0, BLACK);
        mark_test("border");
        add_case(26, 10, 31'(1) << 0, 0, BLACK);
        add_case(26, 10, 31'(1) << 1, 0, WHITE);
        add_case(71, 55, 31'(1) << 15, 0, BLACK);
        add_case(71, 55, ~(31'(1) << 15), 0, WHITE);
        add_case(41, 25, ALT_ODD, 0, BLACK);
        add_case(41, 25, ALT_EVEN, 0, WHITE);
        add_case(20, 17, 31'(1) << 16, 0, BLACK);
        add_case(20, 17, ~(31'(1) << 16), 0, WHITE);
        add_case(80, 47, ALT_EVEN, 0, BLACK);
        add_case(80, 47, ALT_ODD, 0, WHITE);
        add_case(50, 32, ALT_ODD, 0, BLACK);
        add_case(50, 32, ALT_EVEN, 0, WHITE);
        // Crossings take the vertical wall bit
        add_case(26, 17, 31'(1) << 16, 0, WHITE);
        add_case(26, 17, 31'(1) << 0, 0, BLACK);
        add_case(56, 47, 31'(1) << 10, 0, BLACK);
        add_case(56, 47, ~(31'(1) << 10), 0, WHITE);
        mark_test("walls");
        add_case(15, 5, ALL_ZEROS, 0, RED);
        add_case(15, 5, ALL_ZEROS, 1, WHITE);
        add_case(70, 16, ALL_ZEROS, 3, RED);
        add_case(30, 20, ALL_ZEROS, 6, RED);
        add_case(45, 40, ALL_ZEROS, 12, RED);
        add_case(45, 40, ALL_ZEROS, 7, WHITE);
        add_case(80, 58, ALL_ZEROS, 19, RED);
        add_case(80, 58, ALL_ZEROS, 20, WHITE);
        add_case(80, 58, ALL_ZEROS, 31, WHITE);
        add_case(15, 5, ALL_ONES, 31, WHITE);
        mark_test("player cell");
        add_case(5, 30, ALL_ONES, 0, WHITE);
        add_case(10, 2, ALL_ONES, 0, WHITE);
        add_case(90, 30, ALL_ONES, 0, WHITE);
        add_case(50, 0, ALL_ONES, 0, WHITE);
        add_case(50, 63, ALL_ONES, 0, WHITE);
        add_case(95, 63, ALL_ONES, 0, WHITE);
        mark_test("background");
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            c.x        = 7'($unsigned($random(seed)) % 96);
            c.y        = 7'($unsigned($random(seed)) % 64);
            c.maze     = 31'($random(seed));
            c.position = 5'($random(seed));
            c.expected = predict_color(c.x, c.y, c.maze, c.position);
            table_q.push_back(c);
        end
        mark_test("random stream");
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_color(input color_t expected, input string label);
        checks++;
        test_checks++;
        if (oled_data !== expected) begin
            errors++;
            test_errors++;
            $display("Error at %0t ns: oled_data expected %h, got %h (%s)",
                     $time, 16'(expected), 16'(oled_data), label);
        end
    endtask

    task automatic run_reset_test();
        test_checks = 0;
        test_errors = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clock);
            @(negedge clock);
            check_color(BLACK, "reset");
        end
        @(posedge clock);
        arst_n <= 1'b1;
        $display("Test reset: %0d checks, %0d errors", test_checks, test_errors);
    endtask

    // Maze and position trail the coordinate by one cycle
    task automatic apply_cases(input string name, input int first, input int last);
        int n;
        n = last - first;
        test_checks = 0;
        test_errors = 0;
        for (int i = 0; i < n + 2; i++) begin
            @(posedge clock);
            if (i < n) begin
                x <= table_q[first + i].x;
                y <= table_q[first + i].y;
            end
            if (i >= 1 && i <= n) begin
                maze     <= table_q[first + i - 1].maze;
                position <= table_q[first + i - 1].position;
            end
            @(negedge clock);
            if (i >= 2) begin
                check_color(table_q[first + i - 2].expected,
                            $sformatf("%s case %0d", name, i - 2));
            end
        end
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    initial begin
        int first;
        x        = '0;
        y        = '0;
        maze     = '0;
        position = '0;
        arst_n   = 1'b0;
        build_table();
        table_ready = 1'b1;
        run_reset_test();
        first = 0;
        for (int t = 0; t < test_names.size(); t++) begin
            apply_cases(test_names[t], first, test_ends[t]);
            first = test_ends[t];
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        #((table_q.size() + MARGIN_CYCLES) * CLK_PERIOD * 2);
        $display("Timeout: the tests did not finish in the expected time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
